//--- sim.f
verilog/tracker_pkg.sv
verilog/rgb_unpack.sv
verilog/orange_detector.sv
verilog/direction_classifier.sv
verilog/tracker_fsm.sv
verilog/orange_tracker_top.sv
tests/tb_orange_tracker.sv

//--- tests/tracker_patterns.txt
ff F80 888 888 4 0
12 00F 00F 00F 0 4
ff F80 888 888 4 2
ff 888 C45 888 2 1
ff 888 888 FA0 1 3
ff FA6 B45 F30 0 4
ff F80 F80 888 2 1
ff F80 888 F80 4 2
ff 888 F80 F80 2 1
ff F80 F80 F80 2 1
14 F80 888 888 4 0
04 888 888 FA0 1 2
13 F80 888 888 4 0
ff FC0 FB0 888 0 0

//--- tests/tb_orange_tracker.sv
// testbench for the orange tracker driving pattern-file frames against a reference model
`timescale 1ns/100ps

module tb_orange_tracker import tracker_pkg::*; ();

  localparam int LINE_W   = 12;
  localparam int MIN_PIX  = 8;
  localparam int MAX_TESTS = 64;

  logic           clk;
  logic           reset;
  pix_in_t        pix_in;
  logic           ir_valid;
  ir_code_t       ir_code;
  pix_out_t       pix_out;
  dir_t           direction;
  logic           orange_detected;
  count_t         orange_count;
  logic           frame_done;
  drive_cmd_e     drive_cmd;
  tracker_state_e state;

  // pattern table with one entry per file line
  logic [7:0]  ir_tab    [MAX_TESTS];
  pix12_t      seg_tab   [MAX_TESTS][3];
  logic [2:0]  dir_tab   [MAX_TESTS];
  logic [2:0]  drive_tab [MAX_TESTS];
  int          n_tests;

  // expected video for the two pixels in flight
  pix_out_t exp_hist [2];
  logic     hist_valid [2];

  tracker_state_e model_state;
  int errors;
  int tests_passed;
  int tests_failed;
  int cycles;
  int cycle_limit = 200;
  int fd;
  logic [7:0] f_ir;
  pix12_t     f_l;
  pix12_t     f_c;
  pix12_t     f_r;
  logic [2:0] f_dir;
  logic [2:0] f_drv;
  int unsigned seed_val;

  orange_tracker_top #(
    .LINE_WIDTH (LINE_W),
    .MIN_PIXELS (MIN_PIX)
  ) u_dut (
    .clk             (clk),
    .reset           (reset),
    .pix_in          (pix_in),
    .ir_valid        (ir_valid),
    .ir_code         (ir_code),
    .pix_out         (pix_out),
    .direction       (direction),
    .orange_detected (orange_detected),
    .orange_count    (orange_count),
    .frame_done      (frame_done),
    .drive_cmd       (drive_cmd),
    .state           (state)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit grows once the pattern count is known
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, run did not finish", cycles);
    $display(">>> FAIL");
    $finish;
  end

  // orange band straight from the threshold constants
  function automatic logic in_band(input rgb_t c);
    in_band = (c.r >= ORANGE_R_MIN) && (c.g >= ORANGE_G_MIN) &&
              (c.g <= ORANGE_G_MAX) && (c.b <= ORANGE_B_MAX);
  endfunction

  // 4 bit nibble times 0x11 gives the 8 bit channel
  function automatic rgb_t widen(input pix12_t d);
    rgb_t c;
    c.r = 8'(d[11:8] * 8'h11);
    c.g = 8'(d[7:4] * 8'h11);
    c.b = 8'(d[3:0] * 8'h11);
    widen = c;
  endfunction

  function automatic pix_out_t predict_pixel(input pix_in_t p, input logic hl);
    pix_out_t o;
    o.active = p.active;
    o.rgb    = widen(p.data);
    if (!p.active) begin
      o.rgb = '0;
    end else if (hl && in_band(o.rgb)) begin
      o.rgb = {8'h00, 8'hff, 8'h00};
    end
    predict_pixel = o;
  endfunction

  // blank cycle with junk on the data lines
  function automatic pix_in_t blank_pixel(input logic vs);
    pix_in_t p;
    p.data   = pix12_t'($urandom);
    p.active = 1'b0;
    p.vsync  = vs;
    blank_pixel = p;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // one clock that checks the pixel from two cycles back and drives the next inputs
  task automatic step(input pix_in_t p, input logic iv, input ir_code_t code);
    logic hl;
    @(posedge clk);
    #1;
    hl = (model_state == ST_SEARCH) || (model_state == ST_TRACK);
    if (hist_valid[1]) begin
      expect_eq("pix_out", 32'(exp_hist[1]), 32'(pix_out));
    end
    exp_hist[1]   = exp_hist[0];
    hist_valid[1] = hist_valid[0];
    exp_hist[0]   = predict_pixel(p, hl);
    hist_valid[0] = 1'b1;
    pix_in   = p;
    ir_valid = iv;
    ir_code  = code;
  endtask

  task automatic apply_ir(input ir_code_t code);
    case (code)
      IR_STOP:   model_state = ST_IDLE;
      IR_START:  model_state = ST_SEARCH;
      IR_MANUAL: model_state = ST_MANUAL;
      default: begin
      end
    endcase
  endtask

  // 4 lines of 12 active and 3 blank pixels followed by 2 vsync cycles
  task automatic send_frame(input int t);
    pix_in_t p;
    for (int line = 0; line < 4; line++) begin
      for (int col = 0; col < LINE_W; col++) begin
        p.data   = seg_tab[t][col / (LINE_W / 3)];
        p.active = 1'b1;
        p.vsync  = 1'b0;
        step(p, 1'b0, 8'h00);
      end
      repeat (3) step(blank_pixel(1'b0), 1'b0, 8'h00);
    end
    repeat (2) step(blank_pixel(1'b1), 1'b0, 8'h00);
  endtask

  task automatic run_test(input int t);
    int     errs_before;
    int     waits;
    logic   found;
    count_t exp_count;
    logic   exp_det;
    errs_before = errors;
    exp_count   = '0;
    for (int s = 0; s < 3; s++) begin
      if (in_band(widen(seg_tab[t][s]))) exp_count = exp_count + 18'd16;
    end
    exp_det = (exp_count >= MIN_PIX);
    if (ir_tab[t] != 8'hff) begin
      step(blank_pixel(1'b0), 1'b1, ir_tab[t]);
      apply_ir(ir_tab[t]);
    end
    send_frame(t);
    // results due 4 cycles after vsync rises with some slack allowed
    found = 1'b0;
    waits = 0;
    while (!found && waits < 12) begin
      step(blank_pixel(1'b0), 1'b0, 8'h00);
      found = frame_done;
      waits++;
    end
    assert (found) else begin
      $display("test %0d: frame_done never pulsed after the end of the frame", t);
      errors++;
    end
    if (found) begin
      expect_eq("direction", 32'(dir_tab[t]), 32'(direction));
      expect_eq("orange_count", 32'(exp_count), 32'(orange_count));
      expect_eq("orange_detected", 32'(exp_det), 32'(orange_detected));
    end
    if ((model_state == ST_SEARCH) || (model_state == ST_TRACK)) begin
      model_state = exp_det ? ST_TRACK : ST_SEARCH;
    end
    // drive command settles one cycle after frame_done
    step(blank_pixel(1'b0), 1'b0, 8'h00);
    expect_eq("drive_cmd", 32'(drive_tab[t]), 32'(drive_cmd));
    expect_eq("state", 32'(model_state), 32'(state));
    // strobe lasts a single cycle
    expect_eq("frame_done", 32'd0, 32'(frame_done));
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %0d ir %h segs %h %h %h: ok", t, ir_tab[t],
               seg_tab[t][0], seg_tab[t][1], seg_tab[t][2]);
    end else begin
      tests_failed++;
      $display("test %0d ir %h segs %h %h %h: failed", t, ir_tab[t],
               seg_tab[t][0], seg_tab[t][1], seg_tab[t][2]);
    end
  endtask

  initial begin
    seed_val = 32'he2784435;
    seed_val = $urandom(seed_val);
    reset    = 1'b1;
    pix_in   = '0;
    ir_valid = 1'b0;
    ir_code  = '0;
    errors   = 0;
    tests_passed = 0;
    tests_failed = 0;
    n_tests  = 0;
    model_state = ST_IDLE;
    hist_valid[0] = 1'b0;
    hist_valid[1] = 1'b0;
    exp_hist[0] = '0;
    exp_hist[1] = '0;

    // each line holds the ir code (ff for none) and the left centre right colours
    // followed by the expected direction and drive_cmd
    fd = $fopen("tests/tracker_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file tests/tracker_patterns.txt");
    end else begin
      while (n_tests < MAX_TESTS &&
             $fscanf(fd, "%h %h %h %h %h %h\n", f_ir, f_l, f_c, f_r, f_dir, f_drv) == 6) begin
        ir_tab[n_tests]     = f_ir;
        seg_tab[n_tests][0] = f_l;
        seg_tab[n_tests][1] = f_c;
        seg_tab[n_tests][2] = f_r;
        dir_tab[n_tests]    = f_dir;
        drive_tab[n_tests]  = f_drv;
        n_tests++;
      end
      $fclose(fd);
    end
    cycle_limit = n_tests * 80 + 200;

    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // values straight out of reset
    begin
      int errs_before;
      errs_before = errors;
      assert (n_tests > 0) else begin
        $display("pattern file held no usable test lines");
        errors++;
      end
      expect_eq("drive_cmd", 32'(DRV_STOP), 32'(drive_cmd));
      expect_eq("state", 32'(ST_IDLE), 32'(state));
      expect_eq("direction", 32'(DIR_NONE), 32'(direction));
      expect_eq("frame_done", 32'd0, 32'(frame_done));
      if (errors == errs_before) begin
        tests_passed++;
        $display("reset values: ok");
      end else begin
        tests_failed++;
        $display("reset values: failed");
      end
    end

    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    repeat (2) step(blank_pixel(1'b0), 1'b0, 8'h00);

    $display("tests passed %0d, failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/orange_tracker_top.sv
// orange tracker top, pixel pipeline feeding the classifier and the drive FSM
`timescale 1ns/100ps

module orange_tracker_top import tracker_pkg::*; #(
  parameter int LINE_WIDTH = 640,
  parameter int MIN_PIXELS = 8
) (
  input  logic           clk,
  input  logic           reset,
  input  pix_in_t        pix_in,
  input  logic           ir_valid,
  input  ir_code_t       ir_code,
  output pix_out_t       pix_out,
  output dir_t           direction,
  output logic           orange_detected,
  output count_t         orange_count,
  output logic           frame_done,
  output drive_cmd_e     drive_cmd,
  output tracker_state_e state
);

  // stage 1 video and vsync
  pix_out_t unpacked;
  logic     vsync_d;
  // stage 2 flag and vsync
  logic     is_orange;
  logic     vsync_dd;
  logic     highlight_en;

  rgb_unpack u_rgb_unpack (
    .clk      (clk),
    .reset    (reset),
    .pix_in   (pix_in),
    .unpacked (unpacked),
    .vsync_d  (vsync_d)
  );

  orange_detector u_orange_detector (
    .clk          (clk),
    .reset        (reset),
    .unpacked     (unpacked),
    .vsync_d      (vsync_d),
    .highlight_en (highlight_en),
    .pix_out      (pix_out),
    .is_orange    (is_orange),
    .vsync_dd     (vsync_dd)
  );

  direction_classifier #(
    .LINE_WIDTH (LINE_WIDTH),
    .MIN_PIXELS (MIN_PIXELS)
  ) u_direction_classifier (
    .clk             (clk),
    .reset           (reset),
    .active          (pix_out.active),
    .is_orange       (is_orange),
    .vsync           (vsync_dd),
    .direction       (direction),
    .orange_detected (orange_detected),
    .orange_count    (orange_count),
    .frame_done      (frame_done)
  );

  tracker_fsm u_tracker_fsm (
    .clk             (clk),
    .reset           (reset),
    .ir_valid        (ir_valid),
    .ir_code         (ir_code),
    .frame_done      (frame_done),
    .direction       (direction),
    .orange_detected (orange_detected),
    .highlight_en    (highlight_en),
    .drive_cmd       (drive_cmd),
    .state           (state)
  );

endmodule

//--- verilog/tracker_fsm.sv
// tracker control FSM, maps remote keys and frame results onto drive commands
`timescale 1ns/100ps

module tracker_fsm import tracker_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           ir_valid,
  input  ir_code_t       ir_code,
  input  logic           frame_done,
  input  dir_t           direction,
  input  logic           orange_detected,
  output logic           highlight_en,
  output drive_cmd_e     drive_cmd,
  output tracker_state_e state
);

  tracker_state_e state_nxt;
  drive_cmd_e     drive_nxt;

  // steer towards the target third
  function automatic drive_cmd_e dir_to_drive(input dir_t dir);
    case (dir)
      DIR_CENTRE: dir_to_drive = DRV_FORWARD;
      DIR_LEFT:   dir_to_drive = DRV_LEFT;
      DIR_RIGHT:  dir_to_drive = DRV_RIGHT;
      default:    dir_to_drive = DRV_SPIN;
    endcase
  endfunction

  always_comb begin
    state_nxt = state;
    drive_nxt = drive_cmd;

    // frame results, only while searching or tracking
    if (frame_done) begin
      case (state)
        ST_SEARCH, ST_TRACK: begin
          if (orange_detected) begin
            state_nxt = ST_TRACK;
            drive_nxt = dir_to_drive(direction);
          end else begin
            state_nxt = ST_SEARCH;
            drive_nxt = DRV_SPIN;
          end
        end
        default: begin
        end
      endcase
    end

    // a remote key overrides the frame result in the same cycle
    if (ir_valid) begin
      case (ir_code)
        IR_STOP: begin
          state_nxt = ST_IDLE;
          drive_nxt = DRV_STOP;
        end
        IR_START: begin
          state_nxt = ST_SEARCH;
          drive_nxt = DRV_SPIN;
        end
        IR_MANUAL: begin
          state_nxt = ST_MANUAL;
          drive_nxt = DRV_STOP;
        end
        // direct keys only act in manual mode
        IR_FWD: begin
          if (state == ST_MANUAL) drive_nxt = DRV_FORWARD;
        end
        IR_LEFT: begin
          if (state == ST_MANUAL) drive_nxt = DRV_LEFT;
        end
        IR_RIGHT: begin
          if (state == ST_MANUAL) drive_nxt = DRV_RIGHT;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      drive_cmd <= DRV_STOP;
    end else begin
      state     <= state_nxt;
      drive_cmd <= drive_nxt;
    end
  end

  // overlay on while the camera drives the robot
  assign highlight_en = (state == ST_SEARCH) || (state == ST_TRACK);

endmodule

//--- verilog/direction_classifier.sv
// direction classifier, counts orange pixels per third of the line and picks a direction per frame
`timescale 1ns/100ps

module direction_classifier import tracker_pkg::*; #(
  parameter int LINE_WIDTH = 640,
  parameter int MIN_PIXELS = 8
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   active,
  input  logic   is_orange,
  input  logic   vsync,
  output dir_t   direction,
  output logic   orange_detected,
  output count_t orange_count,
  output logic   frame_done
);

  localparam int COL_W = $clog2(LINE_WIDTH + 1);
  localparam logic [COL_W-1:0] LEFT_END   = COL_W'(LINE_WIDTH / 3);
  localparam logic [COL_W-1:0] CENTRE_END = COL_W'((2 * LINE_WIDTH) / 3);
  localparam logic [COL_W-1:0] COL_LAST   = COL_W'(LINE_WIDTH);
  localparam count_t COUNT_MAX = '1;
  localparam count_t MIN_COUNT = count_t'(MIN_PIXELS);

  logic [COL_W-1:0] col;
  count_t cnt_left;
  count_t cnt_centre;
  count_t cnt_right;
  logic vsync_q;
  logic decide;
  logic [$bits(count_t)+1:0] total_wide;
  count_t total;
  dir_t best;

  // column within the active line, held at zero during blanking
  always_ff @(posedge clk) begin
    if (reset) begin
      col <= '0;
    end else if (!active) begin
      col <= '0;
    end else if (col != COL_LAST) begin
      col <= col + 1'b1;
    end
  end

  // vsync edge seen one cycle, decision taken the next
  always_ff @(posedge clk) begin
    if (reset) begin
      vsync_q <= 1'b0;
      decide  <= 1'b0;
    end else begin
      vsync_q <= vsync;
      decide  <= vsync && !vsync_q;
    end
  end

  // saturating accumulators per third
  always_ff @(posedge clk) begin
    if (reset || decide) begin
      cnt_left   <= '0;
      cnt_centre <= '0;
      cnt_right  <= '0;
    end else if (active && is_orange) begin
      if (col < LEFT_END) begin
        if (cnt_left != COUNT_MAX) cnt_left <= cnt_left + 1'b1;
      end else if (col < CENTRE_END) begin
        if (cnt_centre != COUNT_MAX) cnt_centre <= cnt_centre + 1'b1;
      end else begin
        if (cnt_right != COUNT_MAX) cnt_right <= cnt_right + 1'b1;
      end
    end
  end

  // frame total, clipped to the count width
  assign total_wide = {2'b00, cnt_left} + {2'b00, cnt_centre} + {2'b00, cnt_right};
  assign total = (total_wide > {2'b00, COUNT_MAX}) ? COUNT_MAX : total_wide[$bits(count_t)-1:0];

  // largest third wins, centre beats left beats right on a tie
  always_comb begin
    if ((cnt_centre >= cnt_left) && (cnt_centre >= cnt_right)) begin
      best = DIR_CENTRE;
    end else if (cnt_left >= cnt_right) begin
      best = DIR_LEFT;
    end else begin
      best = DIR_RIGHT;
    end
  end

  // results held until the next frame end
  always_ff @(posedge clk) begin
    if (reset) begin
      direction       <= DIR_NONE;
      orange_detected <= 1'b0;
      orange_count    <= '0;
      frame_done      <= 1'b0;
    end else begin
      frame_done <= decide;
      if (decide) begin
        orange_count    <= total;
        orange_detected <= (total >= MIN_COUNT);
        direction       <= (total >= MIN_COUNT) ? best : DIR_NONE;
      end
    end
  end

endmodule

//--- verilog/orange_detector.sv
// orange band detector with green highlight overlay on the video path
`timescale 1ns/100ps

module orange_detector import tracker_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  pix_out_t unpacked,
  input  logic     vsync_d,
  input  logic     highlight_en,
  output pix_out_t pix_out,
  output logic     is_orange,
  output logic     vsync_dd
);

  logic red_ok;
  logic green_ok;
  logic blue_ok;
  logic orange_now;

  // per-channel band checks
  assign red_ok   = (unpacked.rgb.r >= ORANGE_R_MIN);
  assign green_ok = (unpacked.rgb.g >= ORANGE_G_MIN) && (unpacked.rgb.g <= ORANGE_G_MAX);
  assign blue_ok  = (unpacked.rgb.b <= ORANGE_B_MAX);

  // blanked pixels never count
  assign orange_now = unpacked.active && red_ok && green_ok && blue_ok;

  // stage 2 register, flag and vsync kept in step with video
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_out   <= '0;
      is_orange <= 1'b0;
      vsync_dd  <= 1'b0;
    end else begin
      pix_out.active <= unpacked.active;
      if (orange_now && highlight_en) begin
        // paint target pure green
        pix_out.rgb.r <= 8'h00;
        pix_out.rgb.g <= 8'hff;
        pix_out.rgb.b <= 8'h00;
      end else begin
        pix_out.rgb <= unpacked.rgb;
      end
      is_orange <= orange_now;
      vsync_dd  <= vsync_d;
    end
  end

endmodule

//--- verilog/rgb_unpack.sv
// pixel unpack stage, expands 4:4:4 to 8:8:8 and blanks outside the active area
`timescale 1ns/100ps

module rgb_unpack import tracker_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  pix_in_t  pix_in,
  output pix_out_t unpacked,
  output logic     vsync_d
);

  rgb_t expanded;

  // nibble repeat so f maps to ff and 0 to 00
  always_comb begin
    expanded.r = {pix_in.data[11:8], pix_in.data[11:8]};
    expanded.g = {pix_in.data[7:4], pix_in.data[7:4]};
    expanded.b = {pix_in.data[3:0], pix_in.data[3:0]};
    // blanking hides whatever the buffer drives between lines
    if (!pix_in.active) begin
      expanded = '0;
    end
  end

  // stage 1 register
  always_ff @(posedge clk) begin
    if (reset) begin
      unpacked <= '0;
      vsync_d  <= 1'b0;
    end else begin
      unpacked.rgb    <= expanded;
      unpacked.active <= pix_in.active;
      vsync_d         <= pix_in.vsync;
    end
  end

endmodule

//--- verilog/tracker_pkg.sv
// tracker package with shared widths, pixel structs, colour band, remote codes and FSM enums

package tracker_pkg;

  // stored frame buffer pixel in rrrr_gggg_bbbb order
  typedef logic [11:0] pix12_t;

  // one expanded colour channel
  typedef logic [7:0] chan_t;

  // orange pixel count over one frame
  typedef logic [17:0] count_t;

  // one-hot direction with left at the msb and right at the lsb
  typedef logic [2:0] dir_t;

  // key code from the decoded remote
  typedef logic [7:0] ir_code_t;

  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } rgb_t;

  // raw stream from the buffer readout
  typedef struct packed {
    pix12_t data;
    logic   active;
    logic   vsync;
  } pix_in_t;

  // expanded video as it leaves each pipeline stage
  typedef struct packed {
    rgb_t rgb;
    logic active;
  } pix_out_t;

  // orange band with inclusive bounds
  localparam chan_t ORANGE_R_MIN = 8'hc0;
  localparam chan_t ORANGE_G_MIN = 8'h40;
  localparam chan_t ORANGE_G_MAX = 8'hb0;
  localparam chan_t ORANGE_B_MAX = 8'h60;

  // direction encodings
  localparam dir_t DIR_NONE   = 3'b000;
  localparam dir_t DIR_LEFT   = 3'b100;
  localparam dir_t DIR_CENTRE = 3'b010;
  localparam dir_t DIR_RIGHT  = 3'b001;

  // remote key codes
  localparam ir_code_t IR_START  = 8'h12;
  localparam ir_code_t IR_STOP   = 8'h13;
  localparam ir_code_t IR_MANUAL = 8'h14;
  localparam ir_code_t IR_FWD    = 8'h02;
  localparam ir_code_t IR_LEFT   = 8'h04;
  localparam ir_code_t IR_RIGHT  = 8'h06;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEARCH,
    ST_TRACK,
    ST_MANUAL
  } tracker_state_e;

  typedef enum logic [2:0] {
    DRV_STOP,
    DRV_FORWARD,
    DRV_LEFT,
    DRV_RIGHT,
    DRV_SPIN
  } drive_cmd_e;

endpackage
